// File: project.f
hw/audio_board_pkg.sv
hw/mic_i2s_receiver.sv
hw/lab_top.sv
hw/i2s_audio_out.sv
hw/board_top.sv
dv/board_top_props.sv
dv/tb_board_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the board_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_board_top \
    -f project.f \
    --Mdir obj_dir -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_board_top +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
exit 1

// File: dv/tb_board_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_board_top;

    logic        clk = 1'b0;
    logic        rst;
    logic [1:0]  key;                                  // Board pins, active low
    logic [2:0]  sw;
    logic        mic_sd = 1'b0;
    logic [7:0]  led;
    logic        mic_sck;
    logic        mic_ws;
    logic        dac_bclk;
    logic        dac_lrclk;
    logic        dac_sdata;

    int          checks = 0;
    int          errors = 0;
    int          test_checks0;
    int          test_errors0;
    int          words_seen = 0;                       // Complete L/R pairs decoded
    logic        checking = 1'b0;                      // Compare process armed

    logic [31:0] lcg_state = 32'hfba1_f06f;
    logic [23:0] cur_sample = '0;                      // Sample the mic sends now
    logic [23:0] prev_sample = '0;
    logic [23:0] mic_shreg = '0;
    logic [23:0] force_value = '0;
    int          force_count = 0;                      // Requests from the main process
    int          force_used = 0;                       // Requests taken by the mic model
    int          frame_cnt = 0;
    int          bit_pos = 100;
    logic        sck_d = 1'b0;
    logic        ws_d = 1'b0;

    logic        bclk_d = 1'b0;
    logic        lr_last = 1'b0;
    int          pos = 100;                            // bclk rises since lrclk edge
    logic [15:0] word = '0;
    logic [15:0] left_word = '0;
    logic [15:0] last_left = '0;
    logic [31:0] got;
    logic [31:0] exp_cur;
    logic [31:0] exp_prev;
    logic [7:0]  led_want;

    board_top dut_i
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .mic_sd    ( mic_sd    ),
        .led       ( led       ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .dac_bclk  ( dac_bclk  ),
        .dac_lrclk ( dac_lrclk ),
        .dac_sdata ( dac_sdata )
    );

    always #10 clk = ~clk;                             // 20 ns period

    // ----------------------------------------
    // Reference model and compare
    // ----------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected {left, right} for a mic sample at the given pins
    function automatic logic [31:0] expected_sound(input logic [23:0] sample,
                                                   input logic [2:0] sw_v,
                                                   input logic [1:0] key_v);
        logic signed [15:0] up;
        logic signed [15:0] left;
        logic [1:0]         mode;
        up   = sample[23:8];                           // Upper 16 bits
        mode = key_v[0] ? sw_v[1:0] : 2'd0;            // Pressed key mutes
        case (mode)
            2'd1:    left = up;                        // Pass
            2'd2:    left = up >>> 1;                  // Half
            2'd3:    left = (up == 16'sh8000) ? 16'sh7fff : -up;  // Invert, clamped
            default: left = 16'sd0;                    // Mute
        endcase
        return {left, sw_v[2] ? 16'h0000 : left};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] want,
                               input string what);
        checks++;
        if (actual !== want)
        begin
            errors++;
            $display("FAILED %0t: %s got %h expected %h", $time, what, actual, want);
        end
    endtask

    // ----------------------------------------
    // Mic model
    // ----------------------------------------

    always @(negedge clk)
    begin
        if (sck_d && !mic_sck)                         // sck just fell
        begin
            if (mic_ws != ws_d && frame_cnt > 0)       // ws edge, one slot after the last
                check_value(32'(bit_pos), mic_ws ? 32'd31 : 32'd63,
                            "sck falls per ws slot");
            if (ws_d && !mic_ws)                       // Left slot starts
            begin
                if (frame_cnt % 4 == 0)                // New sample every four frames
                begin
                    prev_sample = cur_sample;
                    if (force_count != force_used)
                    begin
                        cur_sample = force_value;
                        force_used = force_count;
                    end
                    else
                    begin
                        lcg_state  = lcg_next(lcg_state);
                        cur_sample = lcg_state[31:8];
                    end
                end
                frame_cnt++;
                mic_shreg = cur_sample;
                bit_pos   = 0;                         // Delay bit comes first
            end
            else
                bit_pos++;
            if (bit_pos >= 1 && bit_pos <= 24)
            begin
                mic_sd    = mic_shreg[23];             // MSB first
                mic_shreg = mic_shreg << 1;
            end
            else
                mic_sd = 1'b0;
        end
        sck_d = mic_sck;
        ws_d  = mic_ws;
    end

    // ----------------------------------------
    // I2S decoder and compare process
    // ----------------------------------------

    always @(posedge clk)
    begin
        if (dac_bclk && !bclk_d)                       // Rising bclk
        begin
            if (dac_lrclk != lr_last)
            begin
                if (pos < 100)                         // First edge ends no full slot
                    check_value(32'(pos), 32'd31, "bclk rises per lrclk slot");
                pos = 0;                               // Delay bit
            end
            else
                pos = pos + 1;
            lr_last = dac_lrclk;
            if (pos >= 1 && pos <= 16)
                word = {word[14:0], dac_sdata};
            if (pos == 16 && !dac_lrclk)
                left_word = word;
            else if (pos == 16)
            begin
                got       = {left_word, word};
                last_left = left_word;
                words_seen++;
                if (checking)
                begin
                    exp_cur  = expected_sound(cur_sample, sw, key);
                    exp_prev = expected_sound(prev_sample, sw, key);
                    if (got == exp_prev)               // Latency spans a sample change
                        check_value(got, exp_prev, "decoded L/R word");
                    else
                        check_value(got, exp_cur, "decoded L/R word");
                end
            end
        end
        bclk_d = dac_bclk;
    end

    // ----------------------------------------
    // Test sequencing
    // ----------------------------------------

    task automatic wait_words(input int n);
        int start;
        int cycles;
        start  = words_seen;
        cycles = 0;
        while (words_seen - start < n && cycles < n * 600 + 600)
        begin
            @(negedge clk);
            cycles++;
        end
        if (words_seen - start < n)
        begin
            errors++;
            $display("no complete DAC word seen within timeout");
        end
    endtask

    task automatic wait_sample(input logic [23:0] v);
        int cycles;
        cycles = 0;
        while (cur_sample != v && cycles < 4000)
        begin
            @(negedge clk);
            cycles++;
        end
        if (cur_sample != v)
        begin
            errors++;
            $display("mic model never started the forced sample");
        end
    endtask

    task automatic wait_left(input logic [15:0] v);
        int cycles;
        cycles = 0;
        while (last_left != v && cycles < 4000)
        begin
            @(negedge clk);
            cycles++;
        end
        if (last_left != v)
        begin
            errors++;
            $display("saturated left word never decoded");
        end
    endtask

    task automatic force_next(input logic [23:0] v);
        @(posedge clk);                                // Mic model reads on negedge
        force_value = v;
        force_count++;
    endtask

    task automatic set_inputs(input logic [2:0] sw_v, input logic [1:0] key_v);
        @(negedge clk);
        sw  = sw_v;
        key = key_v;
    endtask

    task automatic run_window(input logic [2:0] sw_v, input logic [1:0] key_v,
                              input int n);
        set_inputs(sw_v, key_v);
        wait_words(3);                                 // Old mode drains out
        checking = 1'b1;
        wait_words(n);
        checking = 1'b0;
    endtask

    task automatic begin_test();
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 checks - test_checks0, errors - test_errors0);
    endtask

    initial
    begin
        int cycles;
        int fails;
        rst = 1'b1;
        key = 2'b11;
        sw  = 3'b001;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        begin_test();                                  // Outputs quiet after reset
        check_value(32'(led), 32'd0, "led after reset");
        check_value(32'(dac_sdata), 32'd0, "dac_sdata after reset");
        check_value(32'(dac_bclk), 32'd0, "dac_bclk after reset");
        check_value(32'(dac_lrclk), 32'd0, "dac_lrclk after reset");
        cycles = 0;
        while (!mic_sck && cycles < 100)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!mic_sck)
        begin
            errors++;
            $display("mic_sck never rose after reset");
        end
        cycles = 0;
        while (mic_sck && cycles < 100)
        begin
            @(negedge clk);
            cycles++;
        end
        if (mic_sck)
        begin
            errors++;
            $display("mic_sck never fell after rising");
        end
        end_test("reset");

        begin_test();
        set_inputs(3'b001, 2'b11);
        force_next(24'hc35a17);                        // Negative sample
        wait_sample(24'hc35a17);
        run_window(3'b001, 2'b11, 10);
        end_test("pass");

        begin_test();
        run_window(3'b010, 2'b11, 8);
        end_test("half");

        begin_test();
        set_inputs(3'b011, 2'b11);
        wait_words(3);
        checking = 1'b1;
        force_next(24'h800000);                        // Most negative sample
        wait_left(16'h7fff);
        wait_words(4);
        checking = 1'b0;
        end_test("invert");

        begin_test();
        run_window(3'b000, 2'b11, 6);                  // Mute by switches
        run_window(3'b001, 2'b10, 6);                  // key[0] held
        run_window(3'b101, 2'b11, 6);                  // Right channel off
        run_window(3'b111, 2'b11, 6);
        end_test("mute");

        begin_test();
        set_inputs(3'b001, 2'b11);
        repeat (40)
        begin
            repeat (53) @(negedge clk);
            if (led[6:0] == prev_sample[23:17])
                led_want = {1'b0, prev_sample[23:17]};
            else
                led_want = {1'b0, cur_sample[23:17]};
            check_value(32'(led), 32'(led_want), "led level and overrun");
        end
        end_test("led");

        fails = dut_i.i_lab.props_i.assert_fails;
        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, fails);
        if (errors == 0 && fails == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/board_top_props.sv
`timescale 1ns/10ps
`default_nettype none

module board_top_props
(
    input logic                          clk,
    input logic                          rst,
    input logic                          mic_req,
    input logic                          mic_ack,
    input logic                          snd_req,
    input logic                          snd_ack,
    input audio_board_pkg::sound_frame_t snd_frame
);

    int assert_fails = 0;                              // Read by the testbench at the end

    // ----------------------------------------
    // Four-phase rules, both handshakes
    // ----------------------------------------

    mic_req_hold: assert property (@(posedge clk) disable iff (rst)
        mic_req && !mic_ack |=> mic_req)
        else begin assert_fails++; $error("mic_req dropped before mic_ack"); end

    mic_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(mic_req) |-> !mic_ack)
        else begin assert_fails++; $error("mic_req rose with mic_ack high"); end

    snd_req_hold: assert property (@(posedge clk) disable iff (rst)
        snd_req && !snd_ack |=> snd_req)
        else begin assert_fails++; $error("snd_req dropped before snd_ack"); end

    snd_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(snd_req) |-> !snd_ack)
        else begin assert_fails++; $error("snd_req rose with snd_ack high"); end

    // Data frozen while offered
    snd_frame_stable: assert property (@(posedge clk) disable iff (rst)
        snd_req |=> !snd_req || $stable(snd_frame))
        else begin assert_fails++; $error("snd_frame changed under snd_req"); end

endmodule

bind lab_top board_top_props props_i
(
    .clk       ( clk       ),
    .rst       ( rst       ),
    .mic_req   ( mic_req   ),
    .mic_ack   ( mic_ack   ),
    .snd_req   ( snd_req   ),
    .snd_ack   ( snd_ack   ),
    .snd_frame ( snd_frame )
);

`default_nettype wire

// File: hw/board_top.sv
`timescale 1ns/10ps
`default_nettype none

module board_top
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic [audio_board_pkg::w_key-1:0] key,       // Active low
    input  logic [audio_board_pkg::w_sw-1:0]  sw,
    input  logic                              mic_sd,
    output logic [audio_board_pkg::w_led-1:0] led,
    output logic                              mic_sck,
    output logic                              mic_ws,
    output logic                              dac_bclk,
    output logic                              dac_lrclk,
    output logic                              dac_sdata
);
    import audio_board_pkg::*;

    logic [1:0]         rst_sync;                       // Release synchronizer
    logic               rst_int;                        // Reset for all children
    logic [w_key-1:0]   key_int;                        // Active high keys
    logic [w_led-1:0]   lab_led;                        // Unregistered from lab core

    logic               mic_req;
    logic               mic_ack;
    mic_frame_t         mic_frame;

    logic               snd_req;
    logic               snd_ack;
    sound_frame_t       snd_frame;

    // ----------------------------------------
    // Reset and keys
    // ----------------------------------------

    // Assert at once, release after two clk edges
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rst_sync <= 2'b11;
        else
            rst_sync <= {rst_sync[0], 1'b0};
    end

    assign rst_int = rst_sync[1];
    assign key_int = ~key;                              // Board keys pull low

    // ----------------------------------------
    // LED output register
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst_int)
    begin
        if (rst_int)
            led <= '0;
        else
            led <= lab_led;                             // Keeps glitches off the pins
    end

    // ----------------------------------------
    // Lab core and I2S peripherals
    // ----------------------------------------

    mic_i2s_receiver i_microphone
    (
        .clk   ( clk       ),
        .rst   ( rst_int   ),
        .sck   ( mic_sck   ),
        .ws    ( mic_ws    ),
        .sd    ( mic_sd    ),
        .req   ( mic_req   ),
        .ack   ( mic_ack   ),
        .frame ( mic_frame )
    );

    lab_top i_lab
    (
        .clk       ( clk       ),
        .rst       ( rst_int   ),
        .key       ( key_int   ),
        .sw        ( sw        ),
        .mic_req   ( mic_req   ),
        .mic_frame ( mic_frame ),
        .mic_ack   ( mic_ack   ),
        .snd_req   ( snd_req   ),
        .snd_ack   ( snd_ack   ),
        .snd_frame ( snd_frame ),
        .led       ( lab_led   )
    );

    i2s_audio_out i_audio
    (
        .clk   ( clk       ),
        .rst   ( rst_int   ),
        .req   ( snd_req   ),
        .ack   ( snd_ack   ),
        .frame ( snd_frame ),
        .bclk  ( dac_bclk  ),
        .lrclk ( dac_lrclk ),
        .sdata ( dac_sdata )
    );

endmodule

`default_nettype wire

// File: hw/i2s_audio_out.sv
`timescale 1ns/10ps
`default_nettype none

module i2s_audio_out
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    output logic                          ack,
    input  audio_board_pkg::sound_frame_t frame,
    output logic                          bclk,
    output logic                          lrclk,
    output logic                          sdata
);
    import audio_board_pkg::*;

    logic [$clog2(bclk_div)-1:0]  div_cnt;
    logic [$clog2(slot_bits)-1:0] slot_cnt;           // bclk periods in the slot
    logic [2*slot_bits-1:0]       shift;              // Left slot then right slot
    logic                         tick;
    logic                         bclk_fall;
    logic                         slot_end;           // lrclk about to toggle
    logic                         frame_start;        // lrclk about to fall
    sound_frame_t                 hold;               // Replayed until replaced

    // ----------------------------------------
    // Consumer handshake
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ack  <= 1'b0;
            hold <= '0;                               // Silence before first frame
        end
        else if (req && !ack)
        begin
            ack  <= 1'b1;
            hold <= frame;
        end
        else if (ack && !req)
            ack <= 1'b0;
    end

    // ----------------------------------------
    // bclk and lrclk generation
    // ----------------------------------------

    assign tick        = int'(div_cnt) == bclk_div - 1;
    assign bclk_fall   = tick && bclk;
    assign slot_end    = bclk_fall && int'(slot_cnt) == slot_bits - 1;
    assign frame_start = slot_end && lrclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt  <= '0;
            bclk     <= 1'b0;
            lrclk    <= 1'b0;
            slot_cnt <= '0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                bclk <= ~bclk;
            if (bclk_fall)
                slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
            if (slot_end)
                lrclk <= ~lrclk;                      // Low is left
        end
    end

    // ----------------------------------------
    // Serializer
    // ----------------------------------------

    // Bit 63 leaves on every falling bclk so the MSB lags lrclk by one bclk
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shift <= '0;
            sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            sdata <= shift[2*slot_bits-1];           // Last pad bit on reload
            if (frame_start)
                shift <= {hold.left,  {(slot_bits-w_sound){1'b0}},
                          hold.right, {(slot_bits-w_sound){1'b0}}};
            else
                shift <= {shift[2*slot_bits-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: hw/lab_top.sv
`timescale 1ns/10ps
`default_nettype none

module lab_top
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic [audio_board_pkg::w_key-1:0] key,
    input  logic [audio_board_pkg::w_sw-1:0]  sw,
    input  logic                              mic_req,
    input  audio_board_pkg::mic_frame_t       mic_frame,
    output logic                              mic_ack,
    output logic                              snd_req,
    input  logic                              snd_ack,
    output audio_board_pkg::sound_frame_t     snd_frame,
    output logic [audio_board_pkg::w_led-1:0] led
);
    import audio_board_pkg::*;

    mic_frame_t                held;                  // Last accepted mic frame
    logic                      pend;                  // Held frame not yet offered
    logic                      ovr_seen;              // Sticky overrun indicator
    hs_state_t                 snd_state;
    gain_mode_t                mode;
    logic signed [w_sound-1:0] upper;                 // Top bits of the sample
    logic signed [w_sound-1:0] gained;
    sound_frame_t              sound_next;

    // ----------------------------------------
    // Gain selection
    // ----------------------------------------

    assign mode = key[0] ? MODE_MUTE : gain_mode_t'(sw[1:0]);  // Key overrides switches

    always_comb
    begin
        upper = held.sample[w_mic-1 -: w_sound];
        case (mode)
            MODE_PASS:   gained = upper;
            MODE_HALF:   gained = upper >>> 1;       // Sign kept
            MODE_INVERT:
                if (upper == {1'b1, {(w_sound-1){1'b0}}})
                    gained = {1'b0, {(w_sound-1){1'b1}}};  // Clamp at positive max
                else
                    gained = -upper;
            default:     gained = '0;                // Mute
        endcase
        sound_next.left  = gained;
        sound_next.right = sw[2] ? '0 : gained;      // sw[2] silences right
    end

    // ----------------------------------------
    // Mic side consumer and sound side producer
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mic_ack   <= 1'b0;
            held      <= '0;                          // LEDs read dark after reset
            pend      <= 1'b0;
            ovr_seen  <= 1'b0;
            snd_req   <= 1'b0;
            snd_frame <= '0;
            snd_state <= HS_IDLE;
        end
        else
        begin
            // Take a new frame only with the sound side idle
            if (mic_req && !mic_ack && !pend && snd_state == HS_IDLE)
            begin
                mic_ack <= 1'b1;
                held    <= mic_frame;
                pend    <= 1'b1;
                if (mic_frame.overrun)
                    ovr_seen <= 1'b1;
            end
            else if (mic_ack && !mic_req)
                mic_ack <= 1'b0;                      // Fourth phase

            case (snd_state)
                HS_IDLE:
                    if (pend)
                    begin
                        snd_frame <= sound_next;      // Frozen until next idle
                        snd_req   <= 1'b1;
                        pend      <= 1'b0;
                        snd_state <= HS_REQ;
                    end
                HS_REQ:
                    if (snd_ack)
                    begin
                        snd_req   <= 1'b0;
                        snd_state <= HS_DROP;
                    end
                HS_DROP:
                    if (!snd_ack)
                        snd_state <= HS_IDLE;
                default:
                    snd_state <= HS_IDLE;
            endcase
        end
    end

    assign led = {ovr_seen, held.sample[w_mic-1 -: w_led-1]};  // Level bar plus overrun

endmodule

`default_nettype wire

// File: hw/mic_i2s_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module mic_i2s_receiver
(
    input  logic                        clk,
    input  logic                        rst,
    output logic                        sck,
    output logic                        ws,
    input  logic                        sd,
    output logic                        req,
    input  logic                        ack,
    output audio_board_pkg::mic_frame_t frame
);
    import audio_board_pkg::*;

    logic [$clog2(sck_div)-1:0]   div_cnt;
    logic [$clog2(slot_bits)-1:0] slot_cnt;           // sck periods in the slot
    logic [$clog2(w_mic)-1:0]     bit_cnt;            // Captured bits
    logic [w_mic-1:0]             shift;
    logic                         tick;               // sck about to toggle
    logic                         sck_rise;
    logic                         sck_fall;
    logic                         slot_end;           // ws about to toggle
    logic                         done;               // Pulse after the last bit
    logic                         ovr_pend;           // Frame lost since last offer
    rx_state_t                    rx_state;
    hs_state_t                    hs_state;

    // ----------------------------------------
    // sck and ws generation
    // ----------------------------------------

    assign tick     = int'(div_cnt) == sck_div - 1;
    assign sck_rise = tick && !sck;
    assign sck_fall = tick && sck;
    assign slot_end = sck_fall && int'(slot_cnt) == slot_bits - 1;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt  <= '0;
            sck      <= 1'b0;
            ws       <= 1'b0;
            slot_cnt <= '0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                sck <= ~sck;
            if (sck_fall)
                slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
            if (slot_end)
                ws <= ~ws;                            // On the falling sck edge
        end
    end

    // ----------------------------------------
    // Left slot capture
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_state <= RX_WAIT_WS;
            bit_cnt  <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (rx_state)
                RX_WAIT_WS:
                    if (slot_end && ws)
                        rx_state <= RX_SKIP;          // ws falls here
                RX_SKIP:
                    if (sck_rise)
                    begin
                        bit_cnt  <= '0;
                        rx_state <= RX_SHIFT;
                    end
                RX_SHIFT:
                    if (sck_rise)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (int'(bit_cnt) == w_mic - 1)
                        begin
                            done     <= 1'b1;
                            rx_state <= RX_IGNORE;
                        end
                    end
                RX_IGNORE:
                    if (slot_end && !ws)
                        rx_state <= RX_WAIT_WS;       // Into the right slot
                default:
                    rx_state <= RX_WAIT_WS;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_state == RX_SHIFT && sck_rise)
            shift <= {shift[w_mic-2:0], sd};          // MSB arrives first
    end

    // ----------------------------------------
    // Producer handshake with overrun
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            req      <= 1'b0;
            ovr_pend <= 1'b0;
            hs_state <= HS_IDLE;
        end
        else
        begin
            case (hs_state)
                HS_IDLE:
                    if (done)
                    begin
                        req      <= 1'b1;
                        ovr_pend <= 1'b0;             // Reported in this frame
                        hs_state <= HS_REQ;
                    end
                HS_REQ:
                    if (ack)
                    begin
                        req      <= 1'b0;
                        hs_state <= HS_DROP;
                    end
                HS_DROP:
                    if (!ack)
                        hs_state <= HS_IDLE;
                default:
                    hs_state <= HS_IDLE;
            endcase
            if (done && hs_state != HS_IDLE)
                ovr_pend <= 1'b1;                     // Consumer still busy
        end
    end

    always_ff @(posedge clk)
    begin
        if (done && hs_state == HS_IDLE)
        begin
            frame.sample  <= shift;
            frame.overrun <= ovr_pend;
        end
    end

endmodule

`default_nettype wire

// File: hw/audio_board_pkg.sv
`default_nettype none

package audio_board_pkg;

    // ----------------------------------------
    // Clock and divider constants
    // ----------------------------------------

    localparam int clk_mhz   = 50;             // System clock in MHz
    localparam int sck_div   = clk_mhz / 12;   // 4 at 50 MHz so sck is 6.25 MHz
    localparam int bclk_div  = clk_mhz / 12;   // Same rate as the mic side

    // ----------------------------------------
    // Board widths
    // ----------------------------------------

    localparam int w_key     = 2;              // Push buttons
    localparam int w_sw      = 3;              // User switches
    localparam int w_led     = 8;              // Board LEDs
    localparam int w_mic     = 24;             // INMP441 sample width
    localparam int w_sound   = 16;             // DAC word width
    localparam int slot_bits = 32;             // Bit clocks per channel slot

    // Mic sample plus dropped-frame marker
    typedef struct packed {
        logic                    overrun;      // Earlier frame was lost
        logic signed [w_mic-1:0] sample;       // Left slot, MSB first on the wire
    } mic_frame_t;

    // Stereo word pair for the DAC
    typedef struct packed {
        logic signed [w_sound-1:0] left;
        logic signed [w_sound-1:0] right;
    } sound_frame_t;

    // Producer side of a four-phase req/ack
    typedef enum logic [1:0] {
        HS_IDLE,                               // req low and ack low
        HS_REQ,                                // req high and waiting for ack
        HS_DROP                                // req dropped and waiting for ack low
    } hs_state_t;

    // Gain opcodes from sw[1:0]
    typedef enum logic [1:0] {
        MODE_MUTE   = 2'd0,
        MODE_PASS   = 2'd1,
        MODE_HALF   = 2'd2,
        MODE_INVERT = 2'd3
    } gain_mode_t;

    // Receiver position inside the I2S frame
    typedef enum logic [1:0] {
        RX_WAIT_WS,                            // Waiting for ws to fall
        RX_SKIP,                               // I2S delay bit
        RX_SHIFT,                              // Capturing sample bits
        RX_IGNORE                              // Rest of left slot and right slot
    } rx_state_t;

endpackage

`default_nettype wire
